// File: verilog/arya_pkg.sv
`default_nettype none

package arya_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths

	localparam int THREAD_BITS     = 2;
	localparam int NUM_THREADS     = 4;
	localparam int INST_ADDR_WIDTH = 6;  // per-thread pc
	localparam int IMEM_ADDR_WIDTH = 8;  // {thread, pc}
	localparam int INST_WIDTH      = 32;
	localparam int DATA_WIDTH      = 64;
	localparam int REG_ADDR_WIDTH  = 5;
	localparam int MEM_ADDR_WIDTH  = 8;  // store port address
	localparam int SHAMT_WIDTH     = 5;

	// instruction fields, given as low bit and width
	localparam int OPC_LSB   = 26;
	localparam int OPC_WIDTH = 6;
	localparam int RD_LSB    = 21;
	localparam int RS1_LSB   = 16;
	localparam int RS2_LSB   = 11;
	localparam int SHAMT_LSB = 6;
	localparam int IMM_WIDTH = 16; // bits 15..0, sign extended

	////////////////////////////////////////////////////////////////////////////
	// types

	typedef logic [THREAD_BITS-1:0] thread_id_t;

	typedef enum logic [OPC_WIDTH-1:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_ADDI = 6'h06,
		OP_SHLI = 6'h07,
		OP_ST   = 6'h08,
		OP_HALT = 6'h3f
	} opcode_t;

	typedef enum logic {
		TH_IDLE = 1'b0,
		TH_BUSY = 1'b1
	} thread_state_t;

	// decode -> execute
	typedef struct packed {
		logic                      valid;
		thread_id_t                thread;
		opcode_t                   op;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic [DATA_WIDTH-1:0]     a;
		logic [DATA_WIDTH-1:0]     b;          // rs2 or imm
		logic [DATA_WIDTH-1:0]     store_data;
		logic [SHAMT_WIDTH-1:0]    shamt;
	} dx_bundle_t;

	// execute -> writeback
	typedef struct packed {
		logic                      valid;
		thread_id_t                thread;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic                      we;
		logic [DATA_WIDTH-1:0]     result;     // store address for OP_ST
		logic                      is_store;
		logic [DATA_WIDTH-1:0]     store_data;
	} xw_bundle_t;

endpackage

`default_nettype wire

// File: verilog/arya_if.sv
`timescale 1ns/1ps
`default_nettype none

// fetch side of the instruction ram
interface imem_fetch_if;
	logic                                 req;
	logic                                 gnt;   // same cycle as req
	logic [arya_pkg::IMEM_ADDR_WIDTH-1:0] addr;
	logic [arya_pkg::INST_WIDTH-1:0]      rdata; // one cycle after gnt

	modport requester (output req, output addr, input gnt, input rdata);
	modport memory (input req, input addr, output gnt, output rdata);
endinterface

// register file write port
interface regfile_wb_if;
	logic                                we;
	arya_pkg::thread_id_t                thread;
	logic [arya_pkg::REG_ADDR_WIDTH-1:0] rd;
	logic [arya_pkg::DATA_WIDTH-1:0]     data;

	modport source (output we, output thread, output rd, output data);
	modport sink (input we, input thread, input rd, input data);
endinterface

`default_nettype wire

// File: verilog/shared_inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module shared_inst_mem (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 en,
	imem_fetch_if.memory                         fetch,
	input  logic [arya_pkg::IMEM_ADDR_WIDTH-1:0] prog_addr,
	input  logic [arya_pkg::INST_WIDTH-1:0]      prog_data,
	input  logic                                 prog_we,
	input  logic                                 prog_re,
	output logic [arya_pkg::INST_WIDTH-1:0]      prog_rdata
);

	logic [arya_pkg::INST_WIDTH-1:0] ram [2**arya_pkg::IMEM_ADDR_WIDTH];
	logic                                 host_req;
	logic [arya_pkg::IMEM_ADDR_WIDTH-1:0] port_addr;

	////////////////////////////////////////////////////////////////////////////
	// arbiter, host always wins

	assign host_req  = prog_we | prog_re;
	assign fetch.gnt = fetch.req & en & ~host_req; // losing fetch becomes a bubble
	assign port_addr = host_req ? prog_addr : fetch.addr;

	// single port, one access per cycle
	always_ff @(posedge clk) begin
		if (prog_we)
			ram[port_addr] <= prog_data;
		if (fetch.gnt)
			fetch.rdata <= ram[port_addr]; // held while not granted
	end

	// host read-back, works regardless of en
	always_ff @(posedge clk) begin
		if (reset)
			prog_rdata <= '0;
		else if (prog_re)
			prog_rdata <= ram[port_addr];
	end

endmodule

`default_nettype wire

// File: verilog/thread_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module thread_fetch (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               en,
	input  logic [arya_pkg::NUM_THREADS-1:0]   start_thread,
	output logic [arya_pkg::NUM_THREADS-1:0]   thread_busy,
	output logic [arya_pkg::NUM_THREADS-1:0]   thread_done,
	input  logic                               halt_seen,
	input  arya_pkg::thread_id_t               halt_thread,
	imem_fetch_if.requester                    fetch,
	output arya_pkg::thread_id_t               fetch_thread,
	output logic                               fetch_valid
);

	arya_pkg::thread_id_t                 slot; // barrel position
	arya_pkg::thread_state_t              state [arya_pkg::NUM_THREADS];
	logic [arya_pkg::INST_ADDR_WIDTH-1:0] pc [arya_pkg::NUM_THREADS];
	logic [arya_pkg::NUM_THREADS-1:0]     done_q;

	////////////////////////////////////////////////////////////////////////////
	// fetch request for the thread owning this slot

	assign fetch.req  = (state[slot] == arya_pkg::TH_BUSY);
	assign fetch.addr = {slot, pc[slot]};

	always_comb begin
		for (int i = 0; i < arya_pkg::NUM_THREADS; i++)
			thread_busy[i] = (state[i] == arya_pkg::TH_BUSY);
	end

	// pulse held through a freeze, shown once en returns
	assign thread_done = done_q & {arya_pkg::NUM_THREADS{en}};

	////////////////////////////////////////////////////////////////////////////
	// slot counter, per-thread state and pc

	always_ff @(posedge clk) begin
		if (reset) begin
			slot        <= '0;
			fetch_valid <= 1'b0;
			done_q      <= '0;
			for (int i = 0; i < arya_pkg::NUM_THREADS; i++) begin
				state[i] <= arya_pkg::TH_IDLE;
				pc[i]    <= '0;
			end
		end else if (en) begin
			slot         <= slot + 1'b1;
			fetch_valid  <= fetch.gnt;  // word lands on rdata next cycle
			fetch_thread <= slot;
			for (int i = 0; i < arya_pkg::NUM_THREADS; i++) begin
				done_q[i] <= 1'b0;
				if (state[i] == arya_pkg::TH_IDLE) begin
					if (start_thread[i]) begin
						state[i] <= arya_pkg::TH_BUSY;
						pc[i]    <= '0;
					end
				end else if (halt_seen && halt_thread == arya_pkg::thread_id_t'(i)) begin
					// halt reached decode
					state[i]  <= arya_pkg::TH_IDLE;
					pc[i]     <= '0;
					done_q[i] <= 1'b1;
				end else if (fetch.gnt && slot == arya_pkg::thread_id_t'(i)) begin
					pc[i] <= pc[i] + 1'b1; // denied fetch keeps the pc
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/decode_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module decode_regfile (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            en,
	input  logic [arya_pkg::INST_WIDTH-1:0] inst,
	input  arya_pkg::thread_id_t            inst_thread,
	input  logic                            inst_valid,
	regfile_wb_if.sink                      wb,
	output logic                            halt_seen,
	output arya_pkg::thread_id_t            halt_thread,
	output arya_pkg::dx_bundle_t            dx
);

	logic [arya_pkg::OPC_WIDTH-1:0]      raw_op;
	arya_pkg::opcode_t                   op;
	logic [arya_pkg::REG_ADDR_WIDTH-1:0] rd, rs1, rs2;
	logic [arya_pkg::SHAMT_WIDTH-1:0]    shamt;
	logic [arya_pkg::DATA_WIDTH-1:0]     imm, rs1_val, rs2_val;
	arya_pkg::dx_bundle_t                dx_next;

	// one bank of 32 per thread, indexed {thread, reg}
	logic [arya_pkg::DATA_WIDTH-1:0]
		regs [arya_pkg::NUM_THREADS * 2**arya_pkg::REG_ADDR_WIDTH];

	////////////////////////////////////////////////////////////////////////////
	// field split

	assign raw_op = inst[arya_pkg::OPC_LSB +: arya_pkg::OPC_WIDTH];
	assign rd     = inst[arya_pkg::RD_LSB +: arya_pkg::REG_ADDR_WIDTH];
	assign rs1    = inst[arya_pkg::RS1_LSB +: arya_pkg::REG_ADDR_WIDTH];
	assign rs2    = inst[arya_pkg::RS2_LSB +: arya_pkg::REG_ADDR_WIDTH];
	assign shamt  = inst[arya_pkg::SHAMT_LSB +: arya_pkg::SHAMT_WIDTH];
	assign imm    = {{(arya_pkg::DATA_WIDTH - arya_pkg::IMM_WIDTH){inst[arya_pkg::IMM_WIDTH-1]}},
		inst[arya_pkg::IMM_WIDTH-1:0]};

	always_comb begin
		case (raw_op)
			arya_pkg::OP_ADD, arya_pkg::OP_SUB, arya_pkg::OP_AND,
			arya_pkg::OP_OR, arya_pkg::OP_XOR, arya_pkg::OP_ADDI,
			arya_pkg::OP_SHLI, arya_pkg::OP_ST, arya_pkg::OP_HALT:
				op = arya_pkg::opcode_t'(raw_op);
			default:
				op = arya_pkg::OP_NOP; // unknown codes do nothing
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// banked register file

	assign rs1_val = (rs1 == '0) ? '0 : regs[{inst_thread, rs1}];
	assign rs2_val = (rs2 == '0) ? '0 : regs[{inst_thread, rs2}];

	always_ff @(posedge clk) begin
		if (wb.we)
			regs[{wb.thread, wb.rd}] <= wb.data;
	end

	////////////////////////////////////////////////////////////////////////////
	// halt report and dx register

	assign halt_seen   = inst_valid && (op == arya_pkg::OP_HALT);
	assign halt_thread = inst_thread;

	always_comb begin
		dx_next.valid      = inst_valid && (op != arya_pkg::OP_HALT); // halt goes no further
		dx_next.thread     = inst_thread;
		dx_next.op         = op;
		dx_next.rd         = rd;
		dx_next.a          = rs1_val;
		dx_next.store_data = rs2_val;
		dx_next.shamt      = shamt;
		if (op == arya_pkg::OP_ADDI || op == arya_pkg::OP_ST)
			dx_next.b = imm;
		else
			dx_next.b = rs2_val;
	end

	always_ff @(posedge clk) begin
		if (reset)
			dx.valid <= 1'b0;
		else if (en)
			dx <= dx_next;
	end

endmodule

`default_nettype wire

// File: verilog/execute_store.sv
`timescale 1ns/1ps
`default_nettype none

module execute_store (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                en,
	input  arya_pkg::dx_bundle_t                dx,
	regfile_wb_if.source                        wb,
	output logic                                store_valid,
	output arya_pkg::thread_id_t                store_thread,
	output logic [arya_pkg::MEM_ADDR_WIDTH-1:0] store_addr,
	output logic [arya_pkg::DATA_WIDTH-1:0]     store_data
);

	arya_pkg::xw_bundle_t xw_next;
	arya_pkg::xw_bundle_t xw_mem; // memory stage
	arya_pkg::xw_bundle_t xw_wb;  // writeback stage

	////////////////////////////////////////////////////////////////////////////
	// alu

	always_comb begin
		xw_next.valid      = dx.valid;
		xw_next.thread     = dx.thread;
		xw_next.rd         = dx.rd;
		xw_next.store_data = dx.store_data;
		xw_next.is_store   = (dx.op == arya_pkg::OP_ST);
		xw_next.we         = 1'b1;
		case (dx.op)
			arya_pkg::OP_ADD:  xw_next.result = dx.a + dx.b;
			arya_pkg::OP_SUB:  xw_next.result = dx.a - dx.b;
			arya_pkg::OP_AND:  xw_next.result = dx.a & dx.b;
			arya_pkg::OP_OR:   xw_next.result = dx.a | dx.b;
			arya_pkg::OP_XOR:  xw_next.result = dx.a ^ dx.b;
			arya_pkg::OP_ADDI: xw_next.result = dx.a + dx.b;
			arya_pkg::OP_SHLI: xw_next.result = dx.a << dx.shamt;
			arya_pkg::OP_ST: begin
				xw_next.result = dx.a + dx.b; // store address
				xw_next.we     = 1'b0;
			end
			default: begin
				xw_next.result = '0;
				xw_next.we     = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// pipeline registers

	always_ff @(posedge clk) begin
		if (reset) begin
			xw_mem.valid <= 1'b0;
			xw_wb.valid  <= 1'b0;
		end else if (en) begin
			xw_mem <= xw_next;
			xw_wb  <= xw_mem;
		end
	end

	// store port, valid masked during a freeze
	assign store_valid  = xw_mem.valid && xw_mem.is_store && en;
	assign store_thread = xw_mem.thread;
	assign store_addr   = xw_mem.result[arya_pkg::MEM_ADDR_WIDTH-1:0];
	assign store_data   = xw_mem.store_data;

	// register write at the edge that ends this stage
	assign wb.we     = xw_wb.valid && xw_wb.we && en;
	assign wb.thread = xw_wb.thread;
	assign wb.rd     = xw_wb.rd;
	assign wb.data   = xw_wb.result;

endmodule

`default_nettype wire

// File: verilog/arya_core.sv
`timescale 1ns/1ps
`default_nettype none

module arya_core (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                en,
	input  logic [arya_pkg::IMEM_ADDR_WIDTH-1:0] prog_addr,
	input  logic [arya_pkg::INST_WIDTH-1:0]      prog_data,
	input  logic                                prog_we,
	input  logic                                prog_re,
	output logic [arya_pkg::INST_WIDTH-1:0]      prog_rdata,
	input  logic [arya_pkg::NUM_THREADS-1:0]     start_thread,
	output logic [arya_pkg::NUM_THREADS-1:0]     thread_busy,
	output logic [arya_pkg::NUM_THREADS-1:0]     thread_done,
	output logic                                store_valid,
	output logic [arya_pkg::THREAD_BITS-1:0]     store_thread,
	output logic [arya_pkg::MEM_ADDR_WIDTH-1:0]  store_addr,
	output logic [arya_pkg::DATA_WIDTH-1:0]      store_data
);

	imem_fetch_if fetch_bus ();
	regfile_wb_if wb_bus ();

	arya_pkg::thread_id_t fetch_thread;
	logic                 fetch_valid;
	logic                 halt_seen;
	arya_pkg::thread_id_t halt_thread;
	arya_pkg::dx_bundle_t dx;

	////////////////////////////////////////////////////////////////////////////
	// fetch and instruction memory

	shared_inst_mem shared_inst_mem_inst (
		.clk        (clk),
		.reset      (reset),
		.en         (en),
		.fetch      (fetch_bus.memory),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.prog_we    (prog_we),
		.prog_re    (prog_re),
		.prog_rdata (prog_rdata)
	);

	thread_fetch thread_fetch_inst (
		.clk          (clk),
		.reset        (reset),
		.en           (en),
		.start_thread (start_thread),
		.thread_busy  (thread_busy),
		.thread_done  (thread_done),
		.halt_seen    (halt_seen),
		.halt_thread  (halt_thread),
		.fetch        (fetch_bus.requester),
		.fetch_thread (fetch_thread),
		.fetch_valid  (fetch_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// decode, execute, store, writeback

	decode_regfile decode_regfile_inst (
		.clk         (clk),
		.reset       (reset),
		.en          (en),
		.inst        (fetch_bus.rdata), // straight from the ram register
		.inst_thread (fetch_thread),
		.inst_valid  (fetch_valid),
		.wb          (wb_bus.sink),
		.halt_seen   (halt_seen),
		.halt_thread (halt_thread),
		.dx          (dx)
	);

	execute_store execute_store_inst (
		.clk          (clk),
		.reset        (reset),
		.en           (en),
		.dx           (dx),
		.wb           (wb_bus.source),
		.store_valid  (store_valid),
		.store_thread (store_thread),
		.store_addr   (store_addr),
		.store_data   (store_data)
	);

endmodule

`default_nettype wire

// File: sim/arya_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module arya_core_asserts (
	input logic                             clk,
	input logic                             reset,
	input logic                             en,
	input logic [arya_pkg::NUM_THREADS-1:0] thread_busy,
	input logic [arya_pkg::NUM_THREADS-1:0] thread_done,
	input logic                             store_valid
);

	// done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(thread_done & $past(thread_done)) == '0)
		else $error("thread_done stayed high for more than one cycle");

	// frozen core issues no stores
	no_store_frozen: assert property (@(posedge clk) disable iff (reset)
		!en |-> !store_valid)
		else $error("store_valid high while en is low");

	idle_after_reset: assert property (@(posedge clk)
		reset |=> (thread_busy == '0 && thread_done == '0 && !store_valid))
		else $error("core outputs not idle after reset");

endmodule

bind arya_core arya_core_asserts arya_core_asserts_inst (
	.clk         (clk),
	.reset       (reset),
	.en          (en),
	.thread_busy (thread_busy),
	.thread_done (thread_done),
	.store_valid (store_valid)
);

`default_nettype wire

// File: sim/arya_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arya_core_tb;

	localparam int          PROG_LEN    = 18; // words per thread program
	localparam int          TABLE_LEN   = arya_pkg::NUM_THREADS * PROG_LEN;
	localparam int          CYCLE_LIMIT = 40 * TABLE_LEN + 500;
	localparam logic [31:0] SEED        = 32'h7a5f_f6eb;
	localparam logic [5:0]  OP_UNKNOWN  = 6'h15; // no such opcode

	typedef struct packed {
		logic [1:0]  thread;
		logic [5:0]  pc;
		logic [5:0]  op;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [15:0] imm; // rs2 and shamt sit in its upper bits
	} entry_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        en;
	logic [7:0]  prog_addr;
	logic [31:0] prog_data;
	logic        prog_we;
	logic        prog_re;
	logic [31:0] prog_rdata;
	logic [3:0]  start_thread;
	logic [3:0]  thread_busy;
	logic [3:0]  thread_done;
	logic        store_valid;
	logic [1:0]  store_thread;
	logic [7:0]  store_addr;
	logic [63:0] store_data;

	entry_t      prog_tab [TABLE_LEN];
	logic [71:0] exp_store [arya_pkg::NUM_THREADS][PROG_LEN]; // {addr, data}
	int          exp_count [arya_pkg::NUM_THREADS];
	int          got_count [arya_pkg::NUM_THREADS];
	int          done_count [arya_pkg::NUM_THREADS];
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	arya_core arya_core_inst (
		.clk          (clk),
		.reset        (reset),
		.en           (en),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.prog_we      (prog_we),
		.prog_re      (prog_re),
		.prog_rdata   (prog_rdata),
		.start_thread (start_thread),
		.thread_busy  (thread_busy),
		.thread_done  (thread_done),
		.store_valid  (store_valid),
		.store_thread (store_thread),
		.store_addr   (store_addr),
		.store_data   (store_data)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	function automatic logic [31:0] encode_word(input entry_t e);
		return {e.op, e.rd, e.rs1, e.imm};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// program table and reference model

	task automatic add_entry(input int t, input int k, input logic [5:0] op,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [15:0] rnd;
		int          idx;
		rnd = 16'($urandom);
		idx = t * PROG_LEN + k;
		prog_tab[idx].thread = 2'(t);
		prog_tab[idx].pc     = 6'(k);
		prog_tab[idx].op     = op;
		prog_tab[idx].rd     = rd;
		prog_tab[idx].rs1    = rs1;
		if (op == arya_pkg::OP_ADDI)
			prog_tab[idx].imm = rnd;
		else
			prog_tab[idx].imm = {rs2, rnd[10:0]}; // random shamt and store offset
	endtask

	// same register numbers in every thread, immediates differ
	task automatic build_table();
		for (int t = 0; t < arya_pkg::NUM_THREADS; t++) begin
			add_entry(t, 0, arya_pkg::OP_ADDI, 5'd1, 5'd0, 5'd0);
			add_entry(t, 1, arya_pkg::OP_ADDI, 5'd2, 5'd0, 5'd0);
			add_entry(t, 2, arya_pkg::OP_ADD, 5'd3, 5'd1, 5'd2);
			add_entry(t, 3, arya_pkg::OP_SUB, 5'd4, 5'd1, 5'd2);
			add_entry(t, 4, arya_pkg::OP_AND, 5'd5, 5'd1, 5'd2);
			add_entry(t, 5, arya_pkg::OP_OR, 5'd6, 5'd1, 5'd2);
			add_entry(t, 6, arya_pkg::OP_XOR, 5'd7, 5'd1, 5'd2);
			add_entry(t, 7, arya_pkg::OP_SHLI, 5'd8, 5'd1, 5'd0);
			add_entry(t, 8, OP_UNKNOWN, 5'd3, 5'd1, 5'd2); // r3 must keep its sum
			for (int s = 0; s < 8; s++)
				add_entry(t, 9 + s, arya_pkg::OP_ST, 5'd0, 5'd2, 5'(s + 1));
			add_entry(t, 17, arya_pkg::OP_HALT, 5'd0, 5'd0, 5'd0);
		end
	endtask

	task automatic build_expected();
		logic [63:0] mregs [32];
		logic [31:0] w;
		logic [63:0] a, b, imm, res;
		logic        wr;
		logic        halted;
		for (int t = 0; t < arya_pkg::NUM_THREADS; t++) begin
			exp_count[t] = 0;
			halted       = 1'b0;
			for (int r = 0; r < 32; r++)
				mregs[r] = 'x;
			mregs[0] = '0;
			for (int k = 0; k < PROG_LEN && !halted; k++) begin
				w   = encode_word(prog_tab[t * PROG_LEN + k]);
				a   = mregs[w[20:16]];
				b   = mregs[w[15:11]];
				imm = {{48{w[15]}}, w[15:0]};
				wr  = 1'b1;
				res = '0;
				case (w[31:26])
					arya_pkg::OP_ADD:  res = a + b;
					arya_pkg::OP_SUB:  res = a - b;
					arya_pkg::OP_AND:  res = a & b;
					arya_pkg::OP_OR:   res = a | b;
					arya_pkg::OP_XOR:  res = a ^ b;
					arya_pkg::OP_ADDI: res = a + imm;
					arya_pkg::OP_SHLI: res = a << w[10:6];
					arya_pkg::OP_ST: begin
						wr = 1'b0;
						exp_store[t][exp_count[t]] = {8'(a + imm), b};
						exp_count[t]++;
					end
					arya_pkg::OP_HALT: begin
						wr     = 1'b0;
						halted = 1'b1;
					end
					default: wr = 1'b0; // unknown code, nothing happens
				endcase
				if (wr && w[25:21] != 5'd0)
					mregs[w[25:21]] = res;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// store port and done monitor

	always @(posedge clk) begin : store_monitor
		int t;
		if (!reset) begin
			if (store_valid) begin
				t = int'(store_thread);
				checks++;
				if (!en)
					report_error("store_valid high while en is low");
				else if (got_count[t] >= exp_count[t])
					report_error($sformatf("extra store from thread %0d", t));
				else if ({store_addr, store_data} !== exp_store[t][got_count[t]])
					report_error($sformatf("thread %0d store %0d: got %h/%h, expected %h/%h",
						t, got_count[t], store_addr, store_data,
						exp_store[t][got_count[t]][71:64], exp_store[t][got_count[t]][63:0]));
				got_count[t]++;
			end
			for (int i = 0; i < arya_pkg::NUM_THREADS; i++) begin
				if (thread_done[i]) begin
					done_count[i]++;
					checks++;
					if (thread_busy[i] || !en)
						report_error($sformatf("thread %0d done while busy or frozen", i));
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// host load and thread runs

	task automatic load_and_verify();
		for (int i = 0; i < TABLE_LEN; i++) begin
			prog_addr = {prog_tab[i].thread, prog_tab[i].pc};
			prog_data = encode_word(prog_tab[i]);
			prog_we   = 1'b1;
			@(negedge clk);
		end
		prog_we = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			prog_addr = {prog_tab[i].thread, prog_tab[i].pc};
			prog_re   = 1'b1;
			@(negedge clk);
			checks++;
			if (prog_rdata !== encode_word(prog_tab[i]))
				report_error($sformatf("read-back at %h: got %h, expected %h",
					prog_addr, prog_rdata, encode_word(prog_tab[i])));
		end
		prog_re = 1'b0;
	endtask

	task automatic run_threads(input logic freeze);
		int freeze_len;
		for (int t = 0; t < arya_pkg::NUM_THREADS; t++) begin
			got_count[t]  = 0;
			done_count[t] = 0;
		end
		start_thread = '1;
		@(negedge clk);
		start_thread = '0;
		checks++;
		if (thread_busy !== 4'hf)
			report_error($sformatf("thread_busy %b after start", thread_busy));
		if (freeze) begin
			repeat (44) @(negedge clk); // lands among the stores
			freeze_len = 1 + int'($urandom % 16);
			en         = 1'b0;
			repeat (freeze_len) @(negedge clk);
			en = 1'b1;
		end
		while (thread_busy != '0)
			@(negedge clk);
		repeat (8) @(negedge clk); // late stores would show here
		for (int t = 0; t < arya_pkg::NUM_THREADS; t++) begin
			checks++;
			if (got_count[t] != exp_count[t] || done_count[t] != 1)
				report_error($sformatf("thread %0d: %0d stores of %0d, %0d done pulses",
					t, got_count[t], exp_count[t], done_count[t]));
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset        = 1'b1;
		en           = 1'b1;
		prog_addr    = '0;
		prog_data    = '0;
		prog_we      = 1'b0;
		prog_re      = 1'b0;
		start_thread = '0;
		build_table();
		build_expected();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checks++;
		if (thread_busy !== '0 || thread_done !== '0 || store_valid !== 1'b0)
			report_error("outputs not idle after reset");
		load_and_verify();
		run_threads(1'b0);
		run_threads(1'b0); // restart from pc 0
		run_threads(1'b1); // freeze mid-run
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: arya_core.f
verilog/arya_pkg.sv
verilog/arya_if.sv
verilog/shared_inst_mem.sv
verilog/thread_fetch.sv
verilog/decode_regfile.sv
verilog/execute_store.sv
verilog/arya_core.sv
sim/arya_core_asserts.sv
sim/arya_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the arya_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module arya_core_tb -f arya_core.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Varya_core_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" "$log"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1
